//--- project.f
+incdir+hdl
hdl/acia_pkg.sv
hdl/cru_regs.sv
hdl/serial_xmt.sv
hdl/serial_rcv.sv
hdl/acia_top.sv
testbench/acia_asserts.sv
testbench/acia_tb.sv

//--- testbench/acia_tb.sv
/* acia testbench
   loopback table, parity error, interrupt and CTS tests over the CRU port */
`timescale 1ns/1ps
`include "acia_config.svh"

module acia_tb;

  localparam int N_ROWS   = 6;
  localparam int WAIT_MAX = 10000;  // polls per wait, two clocks each

  typedef struct packed {
    logic [1:0] rcl;
    logic       penb;
    logic       podd;
    logic [1:0] sbs;
    logic       div8;
    logic [9:0] rate;
    logic       rnd;   // data from $urandom
    logic [7:0] data;
  } row_t;

  logic        CLK = 1'b0;
  logic        sig_reset;
  logic        ce_n, cruclk, cruout;
  logic [4:0]  s;
  logic        cruin, xout, nrts, ncts, nint;
  logic        rin, rin_drv, loop_en;
  row_t        rows [N_ROWS];
  string       names [N_ROWS];

  always #20 CLK = ~CLK;

  assign rin = loop_en ? xout : rin_drv;  // loopback or hand-made frame

  acia_top UUT (
    .CLK       (CLK),
    .sig_reset (sig_reset),
    .ce_n      (ce_n),
    .cruclk    (cruclk),
    .cruout    (cruout),
    .s         (s),
    .cruin     (cruin),
    .xout      (xout),
    .nrts      (nrts),
    .rin       (rin),
    .ncts      (ncts),
    .nint      (nint)
  );

  // ==============================
  // helpers
  // ==============================
  function automatic row_t make_row(logic [1:0] rcl, logic penb, logic podd,
                                    logic [1:0] sbs, logic div8, logic [9:0] rate,
                                    logic rnd, logic [7:0] data);
    row_t r;
    r = '{rcl: rcl, penb: penb, podd: podd, sbs: sbs, div8: div8,
          rate: rate, rnd: rnd, data: data};
    return r;
  endfunction

  task automatic abort_run();
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_val(string name, logic [7:0] exp, logic [7:0] act);
    assert (exp === act)
    else
    begin
      $display("Fail %s: expected %0h, actual %0h", name, exp, act);
      abort_run();
    end
  endtask

  // strobe high two clocks, then one low with s held
  task automatic cru_write(logic [4:0] addr, logic val);
    @(posedge CLK);
    ce_n   <= 1'b0;
    cruclk <= 1'b1;
    s      <= addr;
    cruout <= val;
    repeat (2) @(posedge CLK);
    cruclk <= 1'b0;
    @(posedge CLK);
    ce_n   <= 1'b1;
  endtask

  task automatic cru_read(logic [4:0] addr, output logic val);
    @(posedge CLK);
    ce_n   <= 1'b0;
    cruclk <= 1'b0;
    s      <= addr;
    @(negedge CLK);
    val = cruin;  // combinational mux, stable mid-cycle
    @(posedge CLK);
    ce_n <= 1'b1;
  endtask

  task automatic wait_bit(logic [4:0] addr, logic val, string name);
    int   n;
    logic b;
    n = 0;
    cru_read(addr, b);
    while (b !== val && n < WAIT_MAX)
    begin
      n++;
      cru_read(addr, b);
    end
    assert (b === val)
    else
    begin
      $display("Timed out in %s waiting for CRU bit %0d to read %0b", name, addr, val);
      abort_run();
    end
  endtask

  task automatic write_bits(int n, logic [10:0] v);
    for (int i = 0; i < n; i++)
      cru_write(5'(i), v[i]);
  endtask

  task automatic read_char(output logic [7:0] c);
    logic b;
    for (int i = 0; i < 8; i++)
    begin
      cru_read(5'(i), b);
      c[i] = b;
    end
  endtask

  // software reset, then control and both rate registers
  task automatic setup_line(row_t r);
    cru_write(`ACIA_A_RESET, 1'b1);
    write_bits(8, {3'b000, r.sbs, r.penb, r.podd, 2'b00, r.rcl});
    write_bits(11, {r.div8, r.rate});  // rdr and xdr both
    write_bits(11, {r.div8, r.rate});  // xdr again, ends lxdr
  endtask

  // 8 data bits plus parity, one stop bit
  task automatic send_frame(logic [7:0] d, logic pbit, int half);
    @(posedge CLK);
    rin_drv <= 1'b0;
    repeat (2 * half) @(posedge CLK);
    for (int i = 0; i < 8; i++)
    begin
      rin_drv <= d[i];
      repeat (2 * half) @(posedge CLK);
    end
    rin_drv <= pbit;
    repeat (2 * half) @(posedge CLK);
    rin_drv <= 1'b1;
    repeat (2 * half) @(posedge CLK);
  endtask

  // ==============================
  // tests
  // ==============================
  task automatic reset_test();
    logic b;
    @(negedge CLK);
    check_val("reset_nint", 1, nint);
    check_val("reset_nrts", 1, nrts);
    check_val("reset_xout", 1, xout);
    cru_read(`ACIA_A_XBRE, b);
    check_val("reset_xbre", 1, b);
    cru_read(`ACIA_A_RBRL, b);
    check_val("reset_rbrl", 0, b);
    cru_read(`ACIA_A_RERR, b);
    check_val("reset_rerr", 0, b);
  endtask

  task automatic loop_row(int i);
    row_t       r;
    logic [7:0] got, exp;
    logic       b;
    r = rows[i];
    setup_line(r);
    cru_write(`ACIA_A_RTSON, 1'b1);
    write_bits(8, {3'b000, r.data});
    wait_bit(`ACIA_A_RBRL, 1'b1, names[i]);
    read_char(got);
    exp = r.data & (8'hFF >> (3 - r.rcl));  // 5 + rcl bits
    check_val(names[i], exp, got);
    cru_read(`ACIA_A_RPER, b);
    check_val({names[i], "_rper"}, 0, b);
    cru_read(`ACIA_A_ROVER, b);
    check_val({names[i], "_rover"}, 0, b);
    cru_read(`ACIA_A_RFER, b);
    check_val({names[i], "_rfer"}, 0, b);
    wait_bit(`ACIA_A_XSRE, 1'b1, names[i]);  // let the stop bits finish
  endtask

  task automatic parity_error_test();
    row_t       r;
    logic [7:0] got;
    logic       b;
    r = make_row(2'd3, 1'b1, 1'b0, 2'd2, 1'b0, 10'd4, 1'b0, 8'h96);
    @(posedge CLK);
    loop_en <= 1'b0;
    setup_line(r);
    repeat (8 * 4 * `ACIA_PRESCALE) @(posedge CLK);  // marking line arms rcv
    send_frame(r.data, ~(^r.data), 4 * `ACIA_PRESCALE);  // even parity, bit flipped
    wait_bit(`ACIA_A_RBRL, 1'b1, "parity_err");
    read_char(got);
    check_val("parity_err_data", r.data, got);
    cru_read(`ACIA_A_RPER, b);
    check_val("parity_err_rper", 1, b);
    cru_read(`ACIA_A_RERR, b);
    check_val("parity_err_rerr", 1, b);
    @(posedge CLK);
    loop_en <= 1'b1;
  endtask

  task automatic interrupt_test();
    row_t r;
    logic b;
    r = make_row(2'd3, 1'b0, 1'b0, 2'd2, 1'b0, 10'd4, 1'b0, 8'h4E);
    setup_line(r);
    cru_write(`ACIA_A_RIENB, 1'b1);
    cru_write(`ACIA_A_RTSON, 1'b1);
    write_bits(8, {3'b000, r.data});
    wait_bit(`ACIA_A_RBRL, 1'b1, "rint");
    @(negedge CLK);
    check_val("rint_nint_low", 0, nint);
    cru_read(`ACIA_A_RINT, b);
    check_val("rint_bit", 1, b);
    cru_write(`ACIA_A_RIENB, 1'b1);  // rewrite drops rbrl
    cru_read(`ACIA_A_RBRL, b);
    check_val("rint_clear_rbrl", 0, b);
    @(negedge CLK);
    check_val("rint_nint_high", 1, nint);
    wait_bit(`ACIA_A_XSRE, 1'b1, "xint");
    cru_write(`ACIA_A_XIENB, 1'b1);
    @(negedge CLK);
    check_val("xint_nint_low", 0, nint);
    cru_read(`ACIA_A_XINT, b);
    check_val("xint_bit", 1, b);
  endtask

  task automatic cts_test();
    row_t       r;
    logic [7:0] got;
    logic       b;
    r = make_row(2'd3, 1'b0, 1'b0, 2'd2, 1'b0, 10'd4, 1'b0, 8'hC3);
    setup_line(r);
    @(posedge CLK);
    ncts <= 1'b1;
    cru_write(`ACIA_A_RTSON, 1'b1);
    write_bits(8, {3'b000, r.data});
    // one 8N1 frame is 20 half-bits of 100 clocks
    repeat (3000)
    begin
      @(negedge CLK);
      check_val("cts_hold_xout", 1, xout);
    end
    cru_read(`ACIA_A_XBRE, b);
    check_val("cts_hold_xbre", 0, b);
    @(posedge CLK);
    ncts <= 1'b0;
    wait_bit(`ACIA_A_XSRE, 1'b0, "cts_start");
    wait_bit(`ACIA_A_XSRE, 1'b1, "cts_done");
    cru_read(`ACIA_A_XSRE, b);
    check_val("cts_xsre", 1, b);
    read_char(got);
    check_val("cts_data", r.data, got);
  endtask

  // ==============================
  // main sequence
  // ==============================
  initial
  begin
    void'($urandom(32'h28d6));
    sig_reset = 1'b1;
    ce_n      = 1'b1;
    cruclk    = 1'b0;
    cruout    = 1'b0;
    s         = '0;
    ncts      = 1'b0;
    rin_drv   = 1'b1;
    loop_en   = 1'b1;

    // rcl penb podd sbs div8 rate rnd data
    rows[0] = make_row(2'd3, 1'b0, 1'b0, 2'd2, 1'b0, 10'd4, 1'b0, 8'hA5);
    rows[1] = make_row(2'd2, 1'b1, 1'b0, 2'd1, 1'b0, 10'd5, 1'b0, 8'h3C);
    rows[2] = make_row(2'd1, 1'b1, 1'b1, 2'd0, 1'b0, 10'd4, 1'b0, 8'hFF);
    rows[3] = make_row(2'd0, 1'b0, 1'b0, 2'd0, 1'b0, 10'd6, 1'b0, 8'h5B);
    rows[4] = make_row(2'd3, 1'b1, 1'b1, 2'd2, 1'b1, 10'd1, 1'b1, 8'h00);
    rows[5] = make_row(2'd3, 1'b0, 1'b0, 2'd1, 1'b0, 10'd3, 1'b1, 8'h00);
    names[0] = "c8_none_1stop";
    names[1] = "c7_even_2stop";
    names[2] = "c6_odd_15stop";
    names[3] = "c5_none_15stop";
    names[4] = "c8_odd_div8";
    names[5] = "c8_none_rand";
    for (int i = 0; i < N_ROWS; i++)
      if (rows[i].rnd)
        rows[i].data = 8'($urandom);

    repeat (16) @(posedge CLK);
    sig_reset <= 1'b0;

    reset_test();
    for (int i = 0; i < N_ROWS; i++)
      loop_row(i);
    parity_error_test();
    interrupt_test();
    cts_test();

    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- testbench/acia_asserts.sv
/* acia top-level checks
   reset, read-port and idle-line properties bound to the top level */
`timescale 1ns/1ps

module acia_asserts (
  input logic CLK,
  input logic sig_reset,
  input logic ce_n,
  input logic cruin,
  input logic nrts,
  input logic xout
);

  // nrts is a flop output, high from the first reset clock on
  rts_off_in_reset: assert property (@(posedge CLK) sig_reset |=> nrts)
    else $error("nrts not high during reset");

  // read port idles low
  cruin_idle: assert property (@(posedge CLK) ce_n |-> !cruin)
    else $error("cruin high while ce_n is high");

  xout_mark_after_reset: assert property (@(posedge CLK) $fell(sig_reset) |-> xout)
    else $error("xout not marking after reset");

endmodule

bind acia_top acia_asserts u_asserts (
  .CLK       (CLK),
  .sig_reset (sig_reset),
  .ce_n      (ce_n),
  .cruin     (cruin),
  .nrts      (nrts),
  .xout      (xout)
);

//--- hdl/acia_top.sv
/* acia top level
   bit-clock prescaler, receive input sync and the three blocks */
`timescale 1ns/1ps
`include "acia_config.svh"

module acia_top (
  input  logic       CLK,
  input  logic       sig_reset,
  input  logic       ce_n,
  input  logic       cruclk,
  input  logic       cruout,
  input  logic [4:0] s,
  output logic       cruin,
  output logic       xout,
  output logic       nrts,
  input  logic       rin,
  input  logic       ncts,
  output logic       nint
);

  localparam int PRE_W = $clog2(`ACIA_PRESCALE);

  logic [PRE_W-1:0]     pre_cnt;
  logic                 bit_tick;
  logic                 rin_s;      // synchronized rin
  acia_pkg::line_cfg_t  cfg;
  acia_pkg::rate_t      xdr;
  acia_pkg::rate_t      rdr;
  logic [7:0]           xbr;
  logic                 xbr_load;
  logic                 rtson;
  logic                 clear;
  logic                 rcv_clear;
  acia_pkg::xmt_stat_t  xstat;
  acia_pkg::rcv_stat_t  rstat;

  // ==============================
  // bit clock and input sync
  // ==============================
  always_ff @(posedge CLK)
  begin
    if (sig_reset || pre_cnt == '0)
      pre_cnt <= PRE_W'(`ACIA_PRESCALE - 1);
    else
      pre_cnt <= pre_cnt - 1'b1;
  end

  assign bit_tick = (pre_cnt == '0);  // one cycle per period

  always_ff @(posedge CLK)
  begin
    rin_s <= rin;
  end

  // ==============================
  // blocks
  // ==============================
  cru_regs u_regs (
    .CLK       (CLK),
    .sig_reset (sig_reset),
    .ce_n      (ce_n),
    .cruclk    (cruclk),
    .cruout    (cruout),
    .s         (s),
    .xstat     (xstat),
    .rstat     (rstat),
    .nrts      (nrts),
    .ncts      (ncts),
    .rin_raw   (rin),
    .cfg       (cfg),
    .xdr       (xdr),
    .rdr       (rdr),
    .xbr       (xbr),
    .xbr_load  (xbr_load),
    .rtson     (rtson),
    .clear     (clear),
    .rcv_clear (rcv_clear),
    .cruin     (cruin),
    .nint      (nint)
  );

  serial_xmt u_xmt (
    .CLK      (CLK),
    .bit_tick (bit_tick),
    .clear    (clear),
    .cfg      (cfg),
    .xdr      (xdr),
    .xbr      (xbr),
    .xbr_load (xbr_load),
    .rtson    (rtson),
    .ncts     (ncts),
    .xout     (xout),
    .nrts     (nrts),
    .xstat    (xstat)
  );

  serial_rcv u_rcv (
    .CLK       (CLK),
    .bit_tick  (bit_tick),
    .rcv_clear (rcv_clear),
    .cfg       (cfg),
    .rdr       (rdr),
    .rin       (rin_s),
    .rstat     (rstat)
  );

endmodule

//--- hdl/serial_rcv.sv
/* serial receiver
   start detect, mid-bit sampling, buffer load and error flags */
`timescale 1ns/1ps
`include "acia_config.svh"

module serial_rcv (
  input  logic                CLK,
  input  logic                bit_tick,
  input  logic                rcv_clear,
  input  acia_pkg::line_cfg_t cfg,
  input  acia_pkg::rate_t     rdr,
  input  logic                rin,
  output acia_pkg::rcv_stat_t rstat
);

  typedef enum logic [2:0] {
    R_IDLE, R_ARMED, R_START, R_BITS, R_PARITY, R_STOP
  } rstate_t;

  rstate_t               state;
  logic [`ACIA_HB_W-1:0] hb_cnt;
  logic                  hb_zero, hb_restart;
  logic [4:0]            half;
  logic [4:0]            data_halves;
  logic [7:0]            rsr, rbr;
  logic                  par;
  logic                  rbrl, rsbd, rfbd, rfer, rover, rper;
  logic                  sample, rbr_load;

  assign data_halves = 5'd10 + {2'b00, cfg.rcl, 1'b0};

  // ==============================
  // half-bit counter
  // ==============================
  assign hb_restart = (state == R_ARMED) && !rin;  // falling edge of start bit
  assign hb_zero    = (hb_cnt == '0);

  always_ff @(posedge CLK)
  begin
    if (rcv_clear || hb_restart || hb_zero)
      hb_cnt <= {rdr.count, 3'b000};
    else if (bit_tick)
      hb_cnt <= hb_cnt - (rdr.div8 ? `ACIA_HB_W'(1) : `ACIA_HB_W'(8));
  end

  // ==============================
  // frame FSM
  // ==============================
  assign sample   = (state == R_BITS) && hb_zero && half[0];  // bit mid-point
  assign rbr_load = (state == R_STOP) && hb_zero && (half == 5'd1);

  always_ff @(posedge CLK)
  begin
    if (rcv_clear)
    begin
      state <= R_IDLE;
      half  <= '0;
      par   <= 1'b0;
      rbrl  <= 1'b0;
      rsbd  <= 1'b0;
      rfbd  <= 1'b0;
      rfer  <= 1'b0;
      rover <= 1'b0;
      rper  <= 1'b0;
    end
    else
    begin
      if (hb_zero && state != R_IDLE && state != R_ARMED)
        half <= half - 1'b1;
      case (state)
        R_IDLE:
        begin
          rsbd <= 1'b0;
          rfbd <= 1'b0;
          if (rin)
            state <= R_ARMED;  // line must be marking first
        end
        R_ARMED:
          if (!rin)
          begin
            half  <= 5'd1;
            state <= R_START;
          end
        R_START:
          if (hb_zero && half == 5'd1)
          begin
            if (rin)
              state <= R_IDLE;  // glitch, not a start bit
            else
            begin
              par   <= 1'b0;
              rsbd  <= 1'b1;
              half  <= data_halves;
              state <= R_BITS;
            end
          end
        R_BITS:
        begin
          if (sample)
          begin
            par  <= par ^ rin;
            rfbd <= 1'b1;
          end
          if (hb_zero && half == 5'd1)
          begin
            half  <= 5'd2;
            state <= cfg.penb ? R_PARITY : R_STOP;
          end
        end
        R_PARITY:
          if (hb_zero && half == 5'd1)
          begin
            par   <= par ^ rin;
            half  <= 5'd2;
            state <= R_STOP;
          end
        R_STOP:
          if (rbr_load)
          begin
            rover <= rbrl;  // previous char never read
            rper  <= cfg.penb & (par ^ cfg.podd);
            rfer  <= !rin;
            rbrl  <= 1'b1;
            state <= R_IDLE;
          end
        default: state <= R_IDLE;
      endcase
    end
  end

  // shift and buffer
  always_ff @(posedge CLK)
  begin
    if (sample)
      rsr <= {rin, rsr[7:1]};
    if (rbr_load)
    begin
      case (cfg.rcl)
        2'd3:    rbr <= rsr;
        2'd2:    rbr <= {1'b0, rsr[7:1]};
        2'd1:    rbr <= {2'b00, rsr[7:2]};
        default: rbr <= {3'b000, rsr[7:3]};  // 5-bit chars
      endcase
    end
  end

  assign rstat = '{rbrl: rbrl, rsbd: rsbd, rfbd: rfbd, rfer: rfer,
                   rover: rover, rper: rper, rbr: rbr};

endmodule

//--- hdl/serial_xmt.sv
/* serial transmitter
   half-bit timing, shift register and frame FSM with RTS/CTS gating */
`timescale 1ns/1ps
`include "acia_config.svh"

module serial_xmt (
  input  logic                CLK,
  input  logic                bit_tick,
  input  logic                clear,
  input  acia_pkg::line_cfg_t cfg,
  input  acia_pkg::rate_t     xdr,
  input  logic [7:0]          xbr,
  input  logic                xbr_load,
  input  logic                rtson,
  input  logic                ncts,
  output logic                xout,
  output logic                nrts,
  output acia_pkg::xmt_stat_t xstat
);

  typedef enum logic [2:0] {X_IDLE, X_START, X_BITS, X_PARITY, X_STOP} xstate_t;

  xstate_t               state;
  logic [`ACIA_HB_W-1:0] hb_cnt;
  logic                  hb_zero, hb_restart;
  logic [4:0]            half;       // half-bits left in this phase
  logic [4:0]            data_halves, stop_halves;
  logic [7:0]            xsr;
  logic                  par, xout_q, rts_q, xbre, xsre;
  logic                  start_ok, xsr_load, xsr_shift;

  assign data_halves = 5'd10 + {2'b00, cfg.rcl, 1'b0};

  always_comb
  begin
    case (cfg.sbs)
      2'b00:   stop_halves = 5'd3;  // 1.5 stop bits
      2'b01:   stop_halves = 5'd4;
      default: stop_halves = 5'd2;
    endcase
  end

  // ==============================
  // half-bit counter
  // ==============================
  assign start_ok   = rtson && !ncts && !xbre;
  assign hb_restart = (state == X_IDLE) && start_ok;
  assign hb_zero    = (hb_cnt == '0);

  always_ff @(posedge CLK)
  begin
    if (clear || hb_restart || hb_zero)
      hb_cnt <= {xdr.count, 3'b000};
    else if (bit_tick)
      hb_cnt <= hb_cnt - (xdr.div8 ? `ACIA_HB_W'(1) : `ACIA_HB_W'(8));
  end

  // ==============================
  // frame FSM
  // ==============================
  assign xsr_load  = (state == X_START) && hb_zero && (half == 5'd1);
  assign xsr_shift = (state == X_BITS) && hb_zero && half[0];  // end of each bit

  always_ff @(posedge CLK)
  begin
    if (clear)
    begin
      state  <= X_IDLE;
      half   <= '0;
      par    <= 1'b0;
      xout_q <= 1'b1;
      rts_q  <= 1'b0;
      xbre   <= 1'b1;
      xsre   <= 1'b1;
    end
    else
    begin
      if (hb_zero && state != X_IDLE)
        half <= half - 1'b1;
      case (state)
        X_IDLE:
        begin
          rts_q <= rtson;  // RTS only changes between frames
          if (start_ok)
          begin
            state  <= X_START;
            xout_q <= 1'b0;
            half   <= 5'd2;
          end
        end
        X_START:
          if (xsr_load)
          begin
            xbre  <= 1'b1;
            xsre  <= 1'b0;
            par   <= 1'b0;
            half  <= data_halves;
            state <= X_BITS;
          end
        X_BITS:
          if (hb_zero)
          begin
            if (half[0])
              par <= par ^ xsr[0];
            if (half == 5'd1 && cfg.penb)
            begin
              xout_q <= par ^ xsr[0] ^ cfg.podd;
              half   <= 5'd2;
              state  <= X_PARITY;
            end
            else if (half == 5'd1)
            begin
              xout_q <= 1'b1;
              half   <= stop_halves;
              state  <= X_STOP;
            end
          end
        X_PARITY:
          if (hb_zero && half == 5'd1)
          begin
            xout_q <= 1'b1;
            half   <= stop_halves;
            state  <= X_STOP;
          end
        X_STOP:
          if (hb_zero && half == 5'd1)
          begin
            xsre  <= 1'b1;
            state <= X_IDLE;
          end
        default: state <= X_IDLE;
      endcase
      if (xbr_load)
        xbre <= 1'b0;  // new character wins over the start-bit release
    end
  end

  always_ff @(posedge CLK)
  begin
    if (xsr_load)
      xsr <= xbr;
    else if (xsr_shift)
      xsr <= {1'b0, xsr[7:1]};  // LSB first
  end

  assign xout  = (state == X_BITS) ? xsr[0] : xout_q;
  assign nrts  = !rts_q;
  assign xstat = '{xbre: xbre, xsre: xsre};

endmodule

//--- hdl/cru_regs.sv
/* CRU register block
   write decode, load-flag sequence, config and buffer registers,
   interrupts and the CRU read mux */
`timescale 1ns/1ps
`include "acia_config.svh"

module cru_regs (
  input  logic                CLK,
  input  logic                sig_reset,
  input  logic                ce_n,
  input  logic                cruclk,
  input  logic                cruout,
  input  logic [4:0]          s,
  input  acia_pkg::xmt_stat_t xstat,
  input  acia_pkg::rcv_stat_t rstat,
  input  logic                nrts,
  input  logic                ncts,
  input  logic                rin_raw,
  output acia_pkg::line_cfg_t cfg,
  output acia_pkg::rate_t     xdr,
  output acia_pkg::rate_t     rdr,
  output logic [7:0]          xbr,
  output logic                xbr_load,
  output logic                rtson,
  output logic                clear,
  output logic                rcv_clear,
  output logic                cruin,
  output logic                nint
);

  logic wr, wr_q, cru_fall;
  logic ldctl, lrdr, lxdr;
  logic rienb, xienb;
  logic ctl_wr, rate_wr, buf_wr;
  logic rint, xint, intr, flag, rcverr;
  logic rd_bit;

  // ==============================
  // write decode
  // ==============================
  assign wr       = !ce_n && cruclk;
  assign cru_fall = wr_q && !cruclk;  // strobe just ended

  assign ctl_wr  = wr && ldctl && (s < 5'd8);
  assign rate_wr = wr && !ldctl && (lrdr || lxdr) && (s <= 5'd10);
  assign buf_wr  = wr && !ldctl && !lrdr && !lxdr && (s < 5'd8);

  assign clear     = sig_reset || (wr && s == `ACIA_A_RESET);
  assign rcv_clear = clear || (wr && s == `ACIA_A_RIENB);

  always_ff @(posedge CLK)
  begin
    if (clear)
    begin
      ldctl    <= 1'b1;  // restart load sequence
      lrdr     <= 1'b1;
      lxdr     <= 1'b1;
      rtson    <= 1'b0;
      rienb    <= 1'b0;
      xienb    <= 1'b0;
      cfg      <= '0;
      rdr      <= '0;
      xdr      <= '0;
      xbr_load <= 1'b0;
      wr_q     <= 1'b0;
    end
    else
    begin
      wr_q     <= wr;
      xbr_load <= buf_wr && (s == 5'd7);  // lines up with xbr contents
      if (ctl_wr)
      begin
        case (s)
          5'd0: cfg.rcl[0] <= cruout;
          5'd1: cfg.rcl[1] <= cruout;
          5'd4: cfg.podd   <= cruout;
          5'd5: cfg.penb   <= cruout;
          5'd6: cfg.sbs[0] <= cruout;
          5'd7: cfg.sbs[1] <= cruout;
          default: ;         // clock select bits not kept
        endcase
      end
      // both rates take the bits while both flags are up
      if (rate_wr && lrdr)
        rdr[s[3:0]] <= cruout;
      if (rate_wr && lxdr)
        xdr[s[3:0]] <= cruout;
      if (wr)
      begin
        case (s)
          `ACIA_A_LXDR:  lxdr  <= cruout;
          `ACIA_A_LRDR:  lrdr  <= cruout;
          `ACIA_A_LDCTL: ldctl <= cruout;
          `ACIA_A_RTSON: rtson <= cruout;
          `ACIA_A_RIENB: rienb <= cruout;
          `ACIA_A_XIENB: xienb <= cruout;
          default: ;
        endcase
      end
      // step the load flags at the end of each register
      if (cru_fall && ldctl && s == 5'd7)
        ldctl <= 1'b0;
      else if (cru_fall && !ldctl && s == `ACIA_A_LAST_DATA)
      begin
        if (lrdr)
          lrdr <= 1'b0;
        else
          lxdr <= 1'b0;
      end
    end
  end

  // transmit buffer
  always_ff @(posedge CLK)
  begin
    if (buf_wr)
      xbr[s[2:0]] <= cruout;
  end

  // ==============================
  // interrupts and read mux
  // ==============================
  assign rint   = rstat.rbrl & rienb;
  assign xint   = xstat.xbre & xienb;
  assign intr   = rint | xint;
  assign nint   = !intr;
  assign flag   = ldctl | lrdr | lxdr;
  assign rcverr = rstat.rfer | rstat.rover | rstat.rper;

  always_comb
  begin
    case (s)
      `ACIA_A_INT:   rd_bit = intr;
      `ACIA_A_FLAG:  rd_bit = flag;
      `ACIA_A_NCTS:  rd_bit = !ncts;
      `ACIA_A_NRTS:  rd_bit = !nrts;
      `ACIA_A_XSRE:  rd_bit = xstat.xsre;
      `ACIA_A_XBRE:  rd_bit = xstat.xbre;
      `ACIA_A_RBRL:  rd_bit = rstat.rbrl;
      `ACIA_A_XINT:  rd_bit = xint;
      `ACIA_A_RINT:  rd_bit = rint;
      `ACIA_A_RIN:   rd_bit = rin_raw;
      `ACIA_A_RSBD:  rd_bit = rstat.rsbd;
      `ACIA_A_RFBD:  rd_bit = rstat.rfbd;
      `ACIA_A_RFER:  rd_bit = rstat.rfer;
      `ACIA_A_ROVER: rd_bit = rstat.rover;
      `ACIA_A_RPER:  rd_bit = rstat.rper;
      `ACIA_A_RERR:  rd_bit = rcverr;
      default:       rd_bit = (s < 5'd8) ? rstat.rbr[s[2:0]] : 1'b0;  // buffer or unused
    endcase
  end

  assign cruin = ce_n ? 1'b0 : rd_bit;

endmodule

//--- hdl/acia_pkg.sv
/* acia shared types
   line format, data-rate and status words passed between the blocks */
`include "acia_config.svh"

package acia_pkg;

  // line format from the control register
  typedef struct packed {
    logic [1:0] rcl;   // char length minus 5
    logic       penb;  // parity enable
    logic       podd;  // odd parity
    logic [1:0] sbs;   // stop bit select
  } line_cfg_t;

  // one data-rate register, bit 10 on top
  typedef struct packed {
    logic                    div8;
    logic [`ACIA_RATE_W-2:0] count;  // half-bit time in bit ticks
  } rate_t;

  // transmitter status
  typedef struct packed {
    logic xbre;  // buffer empty
    logic xsre;  // shift register empty
  } xmt_stat_t;

  // receiver status and buffer
  typedef struct packed {
    logic       rbrl;   // buffer loaded
    logic       rsbd;   // start bit seen
    logic       rfbd;   // first data bit seen
    logic       rfer;   // framing error
    logic       rover;  // overrun
    logic       rper;   // parity error
    logic [7:0] rbr;    // right-justified character
  } rcv_stat_t;

endpackage

//--- hdl/acia_config.svh
/* acia configuration macros
   bit-clock prescale, register widths and CRU bit addresses */
`ifndef ACIA_CONFIG_SVH
`define ACIA_CONFIG_SVH

// ==============================
// timing and widths
// ==============================
`define ACIA_PRESCALE     25  // system clocks per bit tick
`define ACIA_RATE_W       11  // div8 on top, count below
`define ACIA_HB_W         13  // half-bit counter with 3 fraction bits

// ==============================
// CRU write addresses
// ==============================
`define ACIA_A_RESET      31  // software reset
`define ACIA_A_XIENB      19
`define ACIA_A_RIENB      18  // also clears the receiver
`define ACIA_A_RTSON      16
`define ACIA_A_LDCTL      14
`define ACIA_A_LRDR       12
`define ACIA_A_LXDR       11
`define ACIA_A_LAST_DATA  10  // last rate register bit

// ==============================
// CRU read addresses
// ==============================
`define ACIA_A_INT        31
`define ACIA_A_FLAG       30
`define ACIA_A_NCTS       28
`define ACIA_A_NRTS       26
`define ACIA_A_XSRE       23
`define ACIA_A_XBRE       22
`define ACIA_A_RBRL       21
`define ACIA_A_XINT       17
`define ACIA_A_RINT       16
`define ACIA_A_RIN        15
`define ACIA_A_RSBD       14
`define ACIA_A_RFBD       13
`define ACIA_A_RFER       12
`define ACIA_A_ROVER      11
`define ACIA_A_RPER       10
`define ACIA_A_RERR       9

`endif
